/* design/smc_pkg.sv */
package smc_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------

  localparam int DATA_W = 32; // internal (AHB side) data width
  localparam int MEM_W  = 8;  // external memory bus, fixed byte width

  // --------------------------------------------------
  // transfer size
  // --------------------------------------------------

  // size of the internal transfer, valid with valid_access
  typedef enum logic [1:0]
  {
    XSIZ_8  = 2'd0, // byte
    XSIZ_16 = 2'd1, // halfword
    XSIZ_32 = 2'd2  // word
  } xfer_size_t;

  // --------------------------------------------------
  // access counter
  // --------------------------------------------------

  // access number counts down, zero is the last access
  typedef logic [1:0] acc_num_t;

  // starting access numbers, one per transfer size
  localparam acc_num_t ACC_BYTE = 2'd0; // one access
  localparam acc_num_t ACC_HALF = 2'd1; // two accesses
  localparam acc_num_t ACC_WORD = 2'd3; // four accesses

endpackage

/* design/smc_access_if.sv */
// shared access state between sequencer, collector and steering
interface smc_access_if import smc_pkg::*;;

  xfer_size_t          xfer_size;  // registered size, from sequencer
  acc_num_t            access_num; // current access number, from sequencer
  logic                latch_data; // read strobe from outside controller
  logic [MEM_W-1:0]    mem_rdata;  // byte from external memory

  // sequencer owns the size and the count
  modport seq
  (
    output xfer_size,
    output access_num
  );

  // collector stores bytes by access number
  modport collect
  (
    input access_num,
    input latch_data,
    input mem_rdata
  );

  // steering builds the read word and picks the write lane
  modport steer
  (
    input xfer_size,
    input access_num,
    input latch_data,
    input mem_rdata
  );

endinterface

/* design/access_sequencer.sv */
module access_sequencer import smc_pkg::*;
(
  input  logic         sys_clk12,
  input  logic         n_sys_reset12,
  input  logic         valid_access,   // address cycle of a new transfer
  input  xfer_size_t   xfer_size,      // size, valid with valid_access
  input  logic         access_done,    // end of one memory access
  smc_access_if.seq    acc,
  output logic         last_access,    // current access is the last one
  output xfer_size_t   cur_xfer_size   // validated size
);

  acc_num_t start_num; // starting count for the incoming size

  // --------------------------------------------------
  // number of accesses per transfer size
  // --------------------------------------------------

  always_comb
  begin
    case (xfer_size)
      XSIZ_16: start_num = ACC_HALF; // two byte accesses
      XSIZ_32: start_num = ACC_WORD; // four byte accesses
      default: start_num = ACC_BYTE; // byte, or unused code 3
    endcase
  end

  // --------------------------------------------------
  // registered transfer size
  // --------------------------------------------------

  always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
  begin
    if (!n_sys_reset12)
    begin
      acc.xfer_size <= XSIZ_8;
    end
    else if (valid_access)
    begin
      acc.xfer_size <= xfer_size; // held for the whole transfer
    end
  end

  // --------------------------------------------------
  // access counter
  // --------------------------------------------------

  // loads on valid_access, then counts down on each access_done
  always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
  begin
    if (!n_sys_reset12)
    begin
      acc.access_num <= ACC_BYTE;
    end
    else if (valid_access)
    begin
      acc.access_num <= start_num; // new transfer wins over a stray done
    end
    else if (access_done && (acc.access_num != ACC_BYTE))
    begin
      acc.access_num <= acc.access_num - 2'd1; // stays at zero once there
    end
  end

  // last access flag straight from the count
  assign last_access = (acc.access_num == ACC_BYTE);

  // size seen by the rest of the controller
  // bypass the register during the address cycle
  assign cur_xfer_size = valid_access ? xfer_size : acc.xfer_size;

endmodule

/* design/read_collector.sv */
module read_collector import smc_pkg::*;
(
  input  logic                sys_clk12,
  input  logic                n_sys_reset12,
  smc_access_if.collect       acc,
  output logic [DATA_W-1:0]   read_reg  // bytes gathered so far
);

  logic [DATA_W-1:0] read_next; // register value after this latch

  // --------------------------------------------------
  // byte placement by access number
  // --------------------------------------------------

  // access 3 is the first byte of a word read and lands on top
  // lower lanes not yet received are cleared
  always_comb
  begin
    case (acc.access_num)
      2'd3:
      begin
        read_next = {acc.mem_rdata,
                     {(DATA_W-MEM_W){1'b0}}};      // top byte, rest cleared
      end
      2'd2:
      begin
        read_next = {read_reg[DATA_W-1:DATA_W-MEM_W],
                     acc.mem_rdata,
                     {(DATA_W-2*MEM_W){1'b0}}};    // byte 2, low half cleared
      end
      2'd1:
      begin
        read_next = {read_reg[DATA_W-1:2*MEM_W],
                     acc.mem_rdata,
                     {MEM_W{1'b0}}};               // byte 1, low byte cleared
      end
      default:
      begin
        read_next = {read_reg[DATA_W-1:MEM_W],
                     acc.mem_rdata};               // last byte, upper kept
      end
    endcase
  end

  // --------------------------------------------------
  // read register
  // --------------------------------------------------

  // only loads on the read strobe, holds otherwise
  always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
  begin
    if (!n_sys_reset12)
    begin
      read_reg <= '0;
    end
    else if (acc.latch_data)
    begin
      read_reg <= read_next;
    end
  end

  // halfword reads use access 1 then 0, so only the low half is
  // ever written for them
  // byte reads only ever touch lane 0
  // the steering picks the valid lanes by size

endmodule

/* design/bus_steering.sv */
module bus_steering import smc_pkg::*;
(
  smc_access_if.steer         acc,
  input  logic [DATA_W-1:0]   read_reg,    // collected read bytes
  input  logic [DATA_W-1:0]   write_data,  // word from internal bus
  input  acc_num_t            access_num,  // current access number
  output logic [DATA_W-1:0]   read_data,   // word to internal bus
  output logic [MEM_W-1:0]    mem_wdata    // byte to external memory
);

  logic [MEM_W-1:0]   cur_byte;  // newest read byte
  logic [2*MEM_W-1:0] cur_half;  // newest read halfword

  // --------------------------------------------------
  // read word
  // --------------------------------------------------

  // take the memory byte directly in the latch cycle, so the
  // word is ready without waiting a clock for the register
  assign cur_byte = acc.latch_data ? acc.mem_rdata : read_reg[MEM_W-1:0];

  // halfword is register byte 1 above the current low byte
  assign cur_half = {read_reg[2*MEM_W-1:MEM_W], cur_byte};

  always_comb
  begin
    case (acc.xfer_size)
      XSIZ_32:
      begin
        read_data = {read_reg[DATA_W-1:MEM_W], cur_byte}; // full word
      end
      XSIZ_16:
      begin
        read_data = {2{cur_half}};    // halfword in both halves
      end
      default:
      begin
        read_data = {4{cur_byte}};    // byte in all four lanes
      end
    endcase
  end

  // --------------------------------------------------
  // write byte lane
  // --------------------------------------------------

  // high lane goes out first on word writes
  always_comb
  begin
    case (access_num)
      2'd3:
      begin
        mem_wdata = write_data[4*MEM_W-1:3*MEM_W]; // byte 3
      end
      2'd2:
      begin
        mem_wdata = write_data[3*MEM_W-1:2*MEM_W]; // byte 2
      end
      2'd1:
      begin
        mem_wdata = write_data[2*MEM_W-1:MEM_W];   // byte 1
      end
      default:
      begin
        mem_wdata = write_data[MEM_W-1:0];         // byte 0, also byte writes
      end
    endcase
  end

  // internal bus holds write_data for the whole transfer,
  // so no write register is needed here

endmodule

/* design/smc_mac_top.sv */
module smc_mac_top import smc_pkg::*;
(
  input  logic                sys_clk12,
  input  logic                n_sys_reset12,
  input  logic                valid_access,   // address cycle strobe
  input  xfer_size_t          xfer_size,      // size with valid_access
  input  logic                access_done,    // end of each access
  input  logic                latch_data,     // read byte strobe
  input  logic [MEM_W-1:0]    mem_rdata,      // external read byte
  input  logic [DATA_W-1:0]   write_data,     // internal write word
  output acc_num_t            access_num,     // access counter
  output logic                last_access,    // last access of transfer
  output xfer_size_t          cur_xfer_size,  // validated size
  output logic [DATA_W-1:0]   read_data,      // internal read word
  output logic [MEM_W-1:0]    mem_wdata       // external write byte
);

  logic [DATA_W-1:0] read_reg; // collector to steering

  smc_access_if acc ();

  // memory side strobes and data go onto the shared bundle
  assign acc.latch_data = latch_data;
  assign acc.mem_rdata  = mem_rdata;
  assign access_num     = acc.access_num;

  access_sequencer u_seq
  (
    .sys_clk12     (sys_clk12),
    .n_sys_reset12 (n_sys_reset12),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .access_done   (access_done),
    .acc           (acc.seq),
    .last_access   (last_access),
    .cur_xfer_size (cur_xfer_size)
  );

  read_collector u_collect
  (
    .sys_clk12     (sys_clk12),
    .n_sys_reset12 (n_sys_reset12),
    .acc           (acc.collect),
    .read_reg      (read_reg)
  );

  bus_steering u_steer
  (
    .acc           (acc.steer),
    .read_reg      (read_reg),
    .write_data    (write_data),
    .access_num    (acc.access_num),
    .read_data     (read_data),
    .mem_wdata     (mem_wdata)
  );

endmodule

/* sim/mac_checker.sv */
module mac_checker import smc_pkg::*;
(
  input  logic               sys_clk12,
  input  logic               n_sys_reset12,
  input  logic               valid_access,
  input  xfer_size_t         xfer_size,
  input  logic               access_done,
  input  logic               latch_data,
  input  logic [MEM_W-1:0]   mem_rdata,
  input  logic [DATA_W-1:0]  write_data,
  input  acc_num_t           access_num,
  input  logic               last_access,
  input  xfer_size_t         cur_xfer_size,
  input  logic [DATA_W-1:0]  read_data,
  input  logic [MEM_W-1:0]   mem_wdata,
  input  logic [DATA_W-1:0]  file_word,    // expected read word from the test file
  output int                 error_count,
  output int                 check_count
);

  timeunit 1ns;
  timeprecision 100ps;

  int                exp_num;        // expected access counter
  xfer_size_t        exp_size;       // expected registered size
  logic [MEM_W-1:0]  rx_bytes [4];   // read bytes in arrival order
  int                rx_cnt;         // bytes received this transfer
  logic [DATA_W-1:0] exp_rd;         // expected read word once complete
  logic              rd_check;       // read word is known and stable

  initial
  begin
    error_count = 0;
    check_count = 0;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // accesses per size minus one, last access is number zero
  function automatic int start_count(xfer_size_t s);
    case (s)
      XSIZ_32: return 3;  // four bytes
      XSIZ_16: return 1;  // two bytes
      default: return 0;  // single byte
    endcase
  endfunction

  // first byte on top for words, lanes replicated for the short sizes
  function automatic logic [DATA_W-1:0] assemble_word(xfer_size_t s);
    case (s)
      XSIZ_32: return {rx_bytes[0], rx_bytes[1], rx_bytes[2], rx_bytes[3]};
      XSIZ_16: return {2{rx_bytes[0], rx_bytes[1]}};
      default: return {4{rx_bytes[0]}};
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("Fail t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // compare on rising edges, then advance the model
  // --------------------------------------------------

  always @(posedge sys_clk12 or negedge n_sys_reset12)
  begin
    if (!n_sys_reset12)
    begin
      exp_num  = 0;
      exp_size = XSIZ_8;
      rx_cnt   = 0;
      exp_rd   = '0;   // empty register reads as zero
      rd_check = 1'b1;
    end
    else
    begin
      // counter, flag and size
      compare_value("access_num", exp_num, access_num);
      compare_value("last_access", exp_num == 0, last_access);
      compare_value("cur_xfer_size", valid_access ? xfer_size : exp_size, cur_xfer_size);
      // write lane follows the count at all times
      compare_value("mem_wdata", write_data[exp_num*MEM_W +: MEM_W], mem_wdata);

      if (latch_data)
      begin
        rx_bytes[rx_cnt] = mem_rdata;
        if (rx_cnt < 3)
        begin
          rx_cnt++;
        end
        if (exp_num == 0)
        begin
          exp_rd   = assemble_word(exp_size);  // final byte just arrived
          rd_check = 1'b1;
          compare_value("read_data (file)", file_word, read_data);
        end
      end

      // size switches after the address cycle, so stop there
      if (rd_check && !valid_access)
      begin
        compare_value("read_data", exp_rd, read_data);
      end

      if (valid_access)
      begin
        exp_num  = start_count(xfer_size);
        exp_size = xfer_size;
        rx_cnt   = 0;
        rd_check = 1'b0;
      end
      else if (access_done && exp_num != 0)
      begin
        exp_num--;  // holds at zero
      end
    end
  end

endmodule

/* sim/tb_smc_mac.sv */
module tb_smc_mac import smc_pkg::*;;

  timeunit 1ns;
  timeprecision 100ps;

  localparam string TEST_FILE       = "sim/mac_tests.txt";
  localparam int    RST_CYCLES      = 16;
  localparam int    CYCLES_PER_LINE = 6;   // longest transfer, word read plus idle
  localparam int    TIMEOUT_SLACK   = 50;

  logic              sys_clk12;
  logic              n_sys_reset12;
  logic              valid_access;
  xfer_size_t        xfer_size;
  logic              access_done;
  logic              latch_data;
  logic [MEM_W-1:0]  mem_rdata;
  logic [DATA_W-1:0] write_data;
  logic [DATA_W-1:0] file_word;      // expected word for the checker
  acc_num_t          access_num;
  logic              last_access;
  xfer_size_t        cur_xfer_size;
  logic [DATA_W-1:0] read_data;
  logic [MEM_W-1:0]  mem_wdata;
  int                error_count;
  int                check_count;
  int                cycle_count = 0;
  int                cycle_limit = 0;  // set once the file length is known

  smc_mac_top uut
  (
    .sys_clk12     (sys_clk12),
    .n_sys_reset12 (n_sys_reset12),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .access_done   (access_done),
    .latch_data    (latch_data),
    .mem_rdata     (mem_rdata),
    .write_data    (write_data),
    .access_num    (access_num),
    .last_access   (last_access),
    .cur_xfer_size (cur_xfer_size),
    .read_data     (read_data),
    .mem_wdata     (mem_wdata)
  );

  mac_checker u_check
  (
    .sys_clk12     (uut.sys_clk12),
    .n_sys_reset12 (uut.n_sys_reset12),
    .valid_access  (uut.valid_access),
    .xfer_size     (uut.xfer_size),
    .access_done   (uut.access_done),
    .latch_data    (uut.latch_data),
    .mem_rdata     (uut.mem_rdata),
    .write_data    (uut.write_data),
    .access_num    (uut.access_num),
    .last_access   (uut.last_access),
    .cur_xfer_size (uut.cur_xfer_size),
    .read_data     (uut.read_data),
    .mem_wdata     (uut.mem_wdata),
    .file_word     (file_word),
    .error_count   (error_count),
    .check_count   (check_count)
  );

  // --------------------------------------------------
  // clock and watchdog
  // --------------------------------------------------

  always #5 sys_clk12 = ~sys_clk12;

  always @(posedge sys_clk12) cycle_count <= cycle_count + 1;

  initial
  begin : watchdog
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit)
    begin
      @(posedge sys_clk12);
    end
    $display("timeout, run did not finish within %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  // --------------------------------------------------
  // stimulus tasks, all driving on falling edges
  // --------------------------------------------------

  // address cycle, then accesses until the DUT flags the last one
  task automatic run_transfer(input logic [31:0] dir, input xfer_size_t size,
                              input logic [31:0] mem, input logic [31:0] wdata,
                              input logic [31:0] expw);
    int   n;          // accesses this size needs
    int   k;          // accesses issued
    int   sel;        // byte of the mem column for this access
    logic final_seen;
    n = (size == XSIZ_32) ? 4 : ((size == XSIZ_16) ? 2 : 1);
    k = 0;
    final_seen = 1'b0;
    @(negedge sys_clk12);
    valid_access = 1'b1;
    xfer_size    = size;
    write_data   = wdata;   // held for the whole transfer
    file_word    = expw;
    while (!final_seen)
    begin
      @(negedge sys_clk12);
      valid_access = 1'b0;
      xfer_size    = (size == XSIZ_8) ? XSIZ_32 : XSIZ_8; // size only valid in address cycle
      access_done  = 1'b1;
      sel = (k < n) ? (n - 1 - k) : 0;
      if (dir == 0)
      begin
        latch_data = 1'b1;
        mem_rdata  = mem[sel*MEM_W +: MEM_W];  // first byte from the top
      end
      final_seen = last_access;
      k++;
    end
    @(negedge sys_clk12);   // idle cycle between transfers
    access_done = 1'b0;
    latch_data  = 1'b0;
    mem_rdata   = '0;       // memory bus released
  endtask

  // access_done with no transfer running, count must hold at zero
  task automatic pulse_stray_done();
    @(negedge sys_clk12);
    access_done = 1'b1;
    @(negedge sys_clk12);
    access_done = 1'b0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial
  begin : stimulus
    string       line;
    int          fd;
    int          got;
    int          n_lines;
    int          n_fields;
    int          n_tests;
    logic [31:0] dir;
    logic [31:0] size;
    logic [31:0] mem;
    logic [31:0] wdata;
    logic [31:0] expw;
    sys_clk12     = 1'b0;
    n_sys_reset12 = 1'b0;
    valid_access  = 1'b0;
    xfer_size     = XSIZ_8;
    access_done   = 1'b0;
    latch_data    = 1'b0;
    mem_rdata     = '0;
    write_data    = '0;
    file_word     = '0;
    n_lines       = 0;
    n_tests       = 0;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0)
    begin
      $display("could not open test file %s", TEST_FILE);
      $display("** FAIL **");
      $finish;
    end
    else
    begin
      // first pass only sizes the timeout
      while (!$feof(fd))
      begin
        got = $fgets(line, fd);
        if (got > 0)
        begin
          n_lines++;
        end
      end
      $fclose(fd);
      cycle_limit = CYCLES_PER_LINE * n_lines + RST_CYCLES + TIMEOUT_SLACK;

      repeat (RST_CYCLES) @(posedge sys_clk12);
      @(negedge sys_clk12);
      n_sys_reset12 = 1'b1;
      @(negedge sys_clk12);  // one quiet cycle for the reset checks

      fd = $fopen(TEST_FILE, "r");
      while (!$feof(fd))
      begin
        got = $fgets(line, fd);
        if (got > 0 && line.len() > 0 && line[0] != "#")
        begin
          n_fields = $sscanf(line, "%h %h %h %h %h", dir, size, mem, wdata, expw);
          if (n_fields == 5)
          begin
            if (dir == 2)
            begin
              pulse_stray_done();
            end
            else
            begin
              run_transfer(dir, xfer_size_t'(size[1:0]), mem, wdata, expw);
            end
            n_tests++;
          end
        end
      end
      $fclose(fd);

      repeat (2) @(posedge sys_clk12);
      $display("transfers %0d, checks %0d, errors %0d", n_tests, check_count, error_count);
      if (error_count == 0 && n_tests > 0)
      begin
        $display("** PASS **");
      end
      else
      begin
        if (n_tests == 0)
        begin
          $display("no transfers found in the test file");
        end
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

/* sim/mac_tests.txt */
# dir (0 read, 1 write, 2 stray access_done) size (0 byte, 1 half, 2 word) mem_bytes write_word exp_read
# mem_bytes are taken from the low end, the first access gets the highest used byte
0 2 11223344 00000000 11223344
0 1 0000abcd 00000000 abcdabcd
0 0 0000005a 00000000 5a5a5a5a
1 2 00000000 deadbeef 00000000
1 1 00000000 0000cafe 00000000
1 0 00000000 000000a5 00000000
2 0 00000000 00000000 00000000
0 2 f00dface 00000000 f00dface
0 0 000000ff 00000000 ffffffff
0 1 00000180 00000000 01800180
1 2 00000000 01234567 00000000
0 2 80000001 00000000 80000001
0 1 00007e81 00000000 7e817e81
1 1 00000000 89abcdef 00000000
1 0 00000000 76543210 00000000
0 0 00000000 00000000 00000000
2 0 00000000 00000000 00000000
0 2 a5a55a5a 00000000 a5a55a5a
0 2 00ff00ff 00000000 00ff00ff
1 2 00000000 fedcba98 00000000
0 1 0000ffff 00000000 ffffffff
0 0 0000003c 00000000 3c3c3c3c

/* filelist.f */
design/smc_pkg.sv
design/smc_access_if.sv
design/access_sequencer.sv
design/read_collector.sv
design/bus_steering.sv
design/smc_mac_top.sv
sim/mac_checker.sv
sim/tb_smc_mac.sv

/* Bender.yml */
package:
  name: smc_mac

sources:
  - design/smc_pkg.sv
  - design/smc_access_if.sv
  - design/access_sequencer.sv
  - design/read_collector.sv
  - design/bus_steering.sv
  - design/smc_mac_top.sv
  - target: simulation
    files:
      - sim/mac_checker.sv
      - sim/tb_smc_mac.sv
